//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= ks_voice_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/ks_voice_model.svh
`ifndef KS_VOICE_MODEL_SVH
`define KS_VOICE_MODEL_SVH

// one right shifting galois step of the noise register
function automatic logic [23:0] lfsr_step(input logic [23:0] s);
	logic [23:0] r;
	r = s >> 1;
	if (s[0])
	begin
		r = r ^ LFSR_TAPS; // feedback when the lsb falls out
	end
	return r;
endfunction

// noise state times velocity, >>> 7, kept to 24 bits
function automatic sample_t excite_of(input logic [23:0] s, input logic [6:0] vel);
	longint sv;
	longint p;
	sv = longint'($signed(s)); // state read as signed
	p = sv * longint'(vel);
	return sample_t'(p >>> 7);
endfunction

// selected average of the tap history, then decay gain in 1/4096
function automatic sample_t loop_sample(
	input sample_t h0, // newest tap
	input sample_t h1,
	input sample_t h2,
	input sample_t h3,
	input logic [1:0] sel,
	input logic [11:0] decay
);
	longint avg;
	longint p;
	case (sel)
		2'd0: avg = longint'(h0);
		2'd1: avg = (longint'(h0) + longint'(h1)) >>> 1;
		default: avg = (longint'(h0) + longint'(h1) + longint'(h2) + longint'(h3)) >>> 2;
	endcase
	p = avg * longint'(decay);
	return sample_t'(p >>> 12); // back to sample scale
endfunction

`endif

//--- dv/ks_voice_tb.sv
`timescale 1ns/1ps

module ks_voice_tb;
	import ks_pkg::*;

	`include "ks_voice_model.svh"

	localparam int ADDR_W = 10; // ram address width at default ADDR_W
	localparam int DEPTH = 1 << ADDR_W; // ram depth
	localparam int DEB = 4; // debounce length at default DEB_LEN
	localparam int LEN_A = 60; // string length for most tests
	localparam int TOTAL_TICKS = 1600; // rough sum over all tests
	localparam int LIMIT = 4 * TOTAL_TICKS + 200; // cycle budget
	localparam longint NEVER = 64'h7fff_ffff_ffff;

	logic a_clk;
	logic reset_n;
	logic sample_tick;
	logic trig;
	voice_ctrl_t ctrl;
	sample_t sample_out;
	logic out_strobe;

	longint cyc; // edge count, nba so all processes see the same value
	longint press_due; // edge where the pending pluck becomes visible
	int n_checks;
	int n_errs;
	int test_checks;
	int test_errs;
	string cur_test;
	int seed;

	// model state
	int m_n; // tick index since reset
	int m_state; // 0 idle, 1 load, 2 play
	int m_len;
	int m_cnt;
	int m_play; // ticks spent in play
	logic [23:0] m_lfsr;
	sample_t m_exc; // registered excitation
	sample_t m_fb; // registered feedback
	sample_t m_hist [0:3];
	sample_t m_mem [0:DEPTH-1];
	sample_t exp_q [$];
	int idx_q [$];
	longint trend_first;
	longint trend_last;

	ks_voice_top ks_voice_top_i (
		.a_clk (a_clk),
		.reset_n (reset_n),
		.sample_tick (sample_tick),
		.trig (trig),
		.ctrl (ctrl),
		.sample_out (sample_out),
		.out_strobe (out_strobe)
	);

	initial
	begin
		a_clk = 1'b0;
		forever #10 a_clk = ~a_clk; // 20 ns period
	end

	initial
	begin
		cyc = 0;
		sample_tick = 1'b0;
		trig = 1'b0;
		reset_n = 1'b1; // active high
		ctrl = '{decay: 12'd4000, velocity: 7'd127, delay_length: 16'(LEN_A), filt_sel: 2'd0};
		press_due = NEVER;
		n_checks = 0;
		n_errs = 0;
		for (int i = 0; i < DEPTH; i++)
		begin
			m_mem[i] = '0; // matches ram after a full idle sweep
		end
	end

	always @(posedge a_clk)
	begin
		cyc <= cyc + 1;
		sample_tick <= (cyc[1:0] == 2'd3); // tick edges at cyc%4 == 0
	end

	// timeout
	always @(posedge a_clk)
	begin
		if (cyc == LIMIT)
		begin
			$display("run exceeded %0d cycles without finishing", LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check(input string what, input logic signed [63:0] exp,
		input logic signed [63:0] act);
		n_checks++;
		test_checks++;
		if (exp !== act)
		begin
			n_errs++;
			test_errs++;
			$display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	// reference model, one step per accepted tick
	always @(posedge a_clk)
	begin
		sample_t x;
		sample_t tap;
		int idx;
		if (reset_n)
		begin
			m_n = 0;
			m_state = 0;
			m_len = 0;
			m_cnt = 0;
			m_play = 0;
			m_lfsr = LFSR_SEED;
			m_exc = '0;
			m_fb = '0;
			m_hist = '{default: '0};
		end
		else if (sample_tick)
		begin
			idx = -1;
			case (m_state)
				1: x = m_exc;
				2: x = m_fb;
				default: x = '0;
			endcase
			if (m_state == 2)
			begin
				idx = m_play; // play sample number for trend
				m_play++;
			end
			tap = m_mem[ADDR_W'(m_n - m_len + LOOP_LAT)]; // read before write
			m_mem[ADDR_W'(m_n)] = x;
			exp_q.push_back(x);
			idx_q.push_back(idx);
			if (cyc >= press_due)
			begin
				press_due = NEVER; // pluck accepted here
				m_state = 1;
				m_len = int'(ctrl.delay_length);
				m_cnt = 0;
				m_play = 0;
			end
			else if (m_state == 1)
			begin
				m_cnt++;
				if (m_cnt >= m_len)
				begin
					m_state = 2;
				end
			end
			m_exc = excite_of(m_lfsr, ctrl.velocity);
			m_lfsr = lfsr_step(m_lfsr);
			m_fb = loop_sample(m_hist[0], m_hist[1], m_hist[2], m_hist[3], ctrl.filt_sel,
				ctrl.decay); // history before the shift
			m_hist[3] = m_hist[2];
			m_hist[2] = m_hist[1];
			m_hist[1] = m_hist[0];
			m_hist[0] = tap;
			m_n++;
		end
	end

	// compare process
	always @(posedge a_clk)
	begin
		sample_t e;
		int idx;
		longint a;
		if (!reset_n && out_strobe)
		begin
			if (exp_q.size() == 0)
			begin
				n_errs++;
				test_errs++;
				$display("%s: output sample arrived with no expected value", cur_test);
			end
			else
			begin
				e = exp_q.pop_front();
				idx = idx_q.pop_front();
				check("sample", longint'(e), longint'(sample_out));
				a = longint'(sample_out);
				if (a < 0)
				begin
					a = -a;
				end
				if (idx >= 0 && idx < LEN_A)
				begin
					trend_first += a; // first play period
				end
				else if (idx >= 2 * LEN_A && idx < 3 * LEN_A)
				begin
					trend_last += a; // third play period
				end
			end
		end
	end

	task automatic wait_ticks(input int n);
		repeat (n)
		begin
			@(posedge a_clk);
			while (!sample_tick)
			begin
				@(posedge a_clk);
			end
		end
	endtask

	// quiet edge, two away from any tick
	task automatic to_quiet_edge();
		@(posedge a_clk);
		while (cyc[1:0] != 2'd2)
		begin
			@(posedge a_clk);
		end
	endtask

	task automatic set_ctrl(input int len, input int vel, input int sel, input int dec);
		to_quiet_edge();
		ctrl <= '{decay: 12'(dec), velocity: 7'(vel), delay_length: 16'(len), filt_sel: 2'(sel)};
	endtask

	// clean press, pluck shows 2 + DEB cycles later
	task automatic press();
		to_quiet_edge();
		repeat ($urandom_range(3, 0)) @(posedge a_clk); // any phase against the tick
		trig <= 1'b1;
		press_due = cyc + 2 + DEB + 1;
		repeat (3 * DEB) @(posedge a_clk);
		trig <= 1'b0;
	endtask

	task automatic bounce(input int width);
		to_quiet_edge();
		trig <= 1'b1;
		repeat (width) @(posedge a_clk);
		trig <= 1'b0;
		repeat (DEB + 2) @(posedge a_clk);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_checks = 0;
		test_errs = 0;
	endtask

	task automatic end_test();
		repeat (3) @(posedge a_clk); // last strobe compared
		check("unmatched samples", 0, longint'(exp_q.size())); // every tick came out
		$display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
	endtask

	initial
	begin
		seed = 32'hc8d7_d7ce;
		void'($urandom(seed)); // seeded once, sets the press phase
		repeat (3) @(posedge a_clk);
		reset_n <= 1'b0;

		start_test("silence");
		wait_ticks(50);
		end_test();

		start_test("pluck_load");
		press();
		wait_ticks(LEN_A + 20);
		set_ctrl(LEN_A, 20, 0, 4000);
		press();
		wait_ticks(LEN_A + 20);
		end_test();

		start_test("bounce");
		for (int w = 1; w < DEB; w++)
		begin
			bounce(w); // too short to count
		end
		wait_ticks(20);
		press();
		wait_ticks(LEN_A + 10);
		end_test();

		start_test("decay");
		for (int s = 0; s < 3; s++)
		begin
			set_ctrl(LEN_A, 127, s, 4000);
			to_quiet_edge();
			trend_first = 0;
			trend_last = 0;
			press();
			wait_ticks(4 * LEN_A + 4);
			check("trend", 1, longint'(trend_last < trend_first && trend_first > 0));
		end
		end_test();

		start_test("retrigger");
		press(); // string still in play
		wait_ticks(LEN_A + 20);
		end_test();

		start_test("length_change");
		to_quiet_edge();
		reset_n <= 1'b1;
		repeat (3) @(posedge a_clk);
		reset_n <= 1'b0;
		set_ctrl(37, 90, 1, 4000);
		wait_ticks(20);
		press();
		wait_ticks(37 * 3);
		set_ctrl(100, 60, 2, 4000);
		press();
		wait_ticks(200);
		end_test();

		$display("checks %0d, errors %0d", n_checks, n_errs);
		if (n_errs == 0 && n_checks > 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+dv
source/ks_pkg.sv
source/pluck_debounce.sv
source/noise_excite.sv
source/delay_line.sv
source/loop_filter.sv
source/ks_voice_top.sv
dv/ks_voice_tb.sv

//--- source/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
	parameter int ADDR_W = 10 // ram depth must exceed delay_length + 4
) (
	input logic a_clk,
	input logic reset_n, // sync, active high
	input logic sample_tick, // one pulse per sample
	input logic pluck, // from debouncer
	input logic [15:0] delay_length, // loop length in samples
	input ks_pkg::sample_t excite, // noise burst
	input ks_pkg::sample_t fb_sample, // filtered loop return
	output ks_pkg::sample_t tap_sample, // read-ahead ram data
	output logic tap_strobe, // tap_sample valid
	output ks_pkg::sample_t sample_out, // newest written sample
	output logic out_strobe // sample_out valid
);
	import ks_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	localparam logic [1:0] ST_IDLE = 2'd0; // writes silence
	localparam logic [1:0] ST_LOAD = 2'd1; // writes noise burst
	localparam logic [1:0] ST_PLAY = 2'd2; // writes filtered feedback

	sample_t mem [0:DEPTH-1]; // delay ram, inferred
	logic [1:0] state;
	logic [ADDR_W-1:0] wr_ptr; // advances every tick
	logic [ADDR_W-1:0] rd_ptr; // LOOP_LAT ahead of a full period
	logic [LEN_W-1:0] len_q; // length latched at pluck
	logic [LEN_W-1:0] load_cnt; // noise samples written so far
	logic pend; // pluck seen since last tick
	logic take; // pluck accepted at this tick
	sample_t wr_data; // value for this tick

	assign take = pend | pluck; // pluck on the tick cycle counts too

	// modulo depth falls out of the ADDR_W truncation
	assign rd_ptr = wr_ptr - ADDR_W'(len_q) + ADDR_W'(LOOP_LAT);

	// write source per state
	always_comb
	begin
		case (state)
			ST_LOAD: wr_data = excite;
			ST_PLAY: wr_data = fb_sample;
			default: wr_data = '0; // idle flushes old notes out
		endcase
	end

	// ram write port, no writes while in reset
	always_ff @(posedge a_clk)
	begin
		if (sample_tick && !reset_n)
		begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			state <= ST_IDLE;
			wr_ptr <= '0;
			len_q <= '0;
			load_cnt <= '0;
			pend <= 1'b0;
			tap_sample <= '0;
			tap_strobe <= 1'b0;
			sample_out <= '0;
			out_strobe <= 1'b0;
		end
		else
		begin
			tap_strobe <= sample_tick; // one cycle after the tick
			out_strobe <= sample_tick;
			if (sample_tick)
			begin
				wr_ptr <= wr_ptr + 1'b1;
				tap_sample <= mem[rd_ptr]; // old data on address clash
				sample_out <= wr_data; // mirror of the write
				pend <= 1'b0;
				if (take)
				begin
					state <= ST_LOAD; // restart from any state
					len_q <= delay_length;
					load_cnt <= '0;
				end
				else
				begin
					case (state)
						ST_LOAD:
						begin
							load_cnt <= load_cnt + 1'b1;
							if (load_cnt + 1'b1 >= len_q)
							begin
								state <= ST_PLAY; // one full period loaded
							end
						end
						ST_PLAY: state <= ST_PLAY; // loops until next pluck
						default: state <= ST_IDLE;
					endcase
				end
			end
			else if (pluck)
			begin
				pend <= 1'b1; // hold for the next tick
			end
		end
	end

endmodule

//--- source/ks_pkg.sv
package ks_pkg;

	// audio word
	localparam int SAMPLE_W = 24; // signed sample width
	localparam int DECAY_W = 12; // decay gain, units of 1/4096
	localparam int VEL_W = 7; // note velocity width
	localparam int LEN_W = 16; // delay length width

	// ticks from ram read to write of the value computed from it
	localparam int LOOP_LAT = 2; // read address runs this far ahead

	// noise source
	localparam logic [23:0] LFSR_SEED = 24'h5a_c3e1; // any nonzero start
	localparam logic [23:0] LFSR_TAPS = 24'he1_0000; // x^24+x^23+x^22+x^17+1

	typedef logic signed [SAMPLE_W-1:0] sample_t; // one audio sample

	// settings of one note
	typedef struct packed {
		logic [DECAY_W-1:0] decay; // loop gain
		logic [VEL_W-1:0] velocity; // attack level
		logic [LEN_W-1:0] delay_length; // pitch period in samples
		logic [1:0] filt_sel; // 0 one tap, 1 two taps, 2/3 four taps
	} voice_ctrl_t; // 37 bits

endpackage

//--- source/ks_voice_top.sv
`timescale 1ns/1ps

module ks_voice_top #(
	parameter int ADDR_W = 10, // delay ram address width
	parameter int DEB_LEN = 4 // trigger debounce cycles
) (
	input logic a_clk,
	input logic reset_n, // sync, active high
	input logic sample_tick, // audio rate strobe
	input logic trig, // raw pluck trigger
	input ks_pkg::voice_ctrl_t ctrl, // note settings
	output ks_pkg::sample_t sample_out, // voice output
	output logic out_strobe // sample_out valid
);
	import ks_pkg::*;

	logic pluck; // debounced press
	sample_t excite; // noise burst sample
	sample_t tap_sample; // ram tap to filter
	logic tap_strobe;
	sample_t fb_sample; // filter back to ram

	pluck_debounce #(.DEB_LEN(DEB_LEN)) pluck_debounce_i (
		.a_clk (a_clk),
		.reset_n (reset_n),
		.trig (trig),
		.pluck (pluck)
	);

	noise_excite noise_excite_i (
		.a_clk (a_clk),
		.reset_n (reset_n),
		.sample_tick (sample_tick),
		.velocity (ctrl.velocity),
		.excite (excite)
	);

	delay_line #(.ADDR_W(ADDR_W)) delay_line_i (
		.a_clk (a_clk),
		.reset_n (reset_n),
		.sample_tick (sample_tick),
		.pluck (pluck),
		.delay_length (ctrl.delay_length),
		.excite (excite),
		.fb_sample (fb_sample),
		.tap_sample (tap_sample),
		.tap_strobe (tap_strobe),
		.sample_out (sample_out),
		.out_strobe (out_strobe)
	);

	loop_filter loop_filter_i (
		.a_clk (a_clk),
		.reset_n (reset_n),
		.tap_strobe (tap_strobe),
		.tap_sample (tap_sample),
		.decay (ctrl.decay),
		.filt_sel (ctrl.filt_sel),
		.fb_sample (fb_sample)
	);

endmodule

//--- source/loop_filter.sv
`timescale 1ns/1ps

module loop_filter (
	input logic a_clk,
	input logic reset_n, // sync, active high
	input logic tap_strobe, // new tap from delay ram
	input ks_pkg::sample_t tap_sample, // read-ahead tap
	input logic [11:0] decay, // gain in 1/4096
	input logic [1:0] filt_sel, // averaging depth
	output ks_pkg::sample_t fb_sample // back into the delay line
);
	import ks_pkg::*;

	sample_t hist [0:3]; // hist[0] newest
	logic signed [SAMPLE_W:0] sum2; // two newest taps
	logic signed [SAMPLE_W+1:0] sum4; // all four taps
	sample_t avg; // selected low pass output
	logic signed [36:0] prod; // avg times decay

	assign sum2 = hist[0] + hist[1]; // sign extended to 25 bits
	assign sum4 = sum2 + hist[2] + hist[3];

	// averaging depth sets how dark the tone gets
	always_comb
	begin
		case (filt_sel)
			2'd0: avg = hist[0]; // no smoothing
			2'd1: avg = sum2[SAMPLE_W:1]; // /2
			default: avg = sum4[SAMPLE_W+1:2]; // /4
		endcase
	end

	assign prod = avg * $signed({1'b0, decay}); // decay always positive

	// fb uses history before this shift, so two ticks of loop latency
	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			hist <= '{default: '0};
			fb_sample <= '0;
		end
		else if (tap_strobe)
		begin
			hist[0] <= tap_sample;
			hist[1] <= hist[0];
			hist[2] <= hist[1];
			hist[3] <= hist[2];
			fb_sample <= prod[35:12]; // back to sample scale
		end
	end

endmodule

//--- source/noise_excite.sv
`timescale 1ns/1ps

module noise_excite (
	input logic a_clk,
	input logic reset_n, // sync, active high
	input logic sample_tick, // one pulse per sample
	input logic [6:0] velocity, // note velocity 0..127
	output ks_pkg::sample_t excite // scaled noise sample
);
	import ks_pkg::*;

	logic [23:0] lfsr; // galois register
	logic [23:0] lfsr_next; // one step ahead
	logic signed [30:0] scaled; // 24b noise times 8b velocity

	// right shifting galois step
	always_comb
	begin
		if (lfsr[0])
		begin
			lfsr_next = (lfsr >> 1) ^ LFSR_TAPS; // feedback on lsb out
		end
		else
		begin
			lfsr_next = lfsr >> 1;
		end
	end

	// velocity kept positive by the zero pad
	assign scaled = $signed(lfsr) * $signed({1'b0, velocity});

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			lfsr <= LFSR_SEED; // never zero
			excite <= '0;
		end
		else if (sample_tick)
		begin
			lfsr <= lfsr_next; // one step per sample
			excite <= scaled[30:7]; // >>> 7 then keep 24 bits
		end
	end

endmodule

//--- source/pluck_debounce.sv
`timescale 1ns/1ps

module pluck_debounce #(
	parameter int DEB_LEN = 4 // cycles the input must hold
) (
	input logic a_clk,
	input logic reset_n, // sync, active high
	input logic trig, // raw async trigger
	output logic pluck // one cycle per confirmed press
);

	localparam int CNT_W = $clog2(DEB_LEN + 1); // room for DEB_LEN-1 at DEB_LEN=1 too

	logic [1:0] sync_q; // two flop synchronizer
	logic deb_state; // debounced trigger level
	logic [CNT_W-1:0] deb_cnt; // cycles of disagreement
	logic differ; // synced level disagrees with state

	assign differ = sync_q[1] ^ deb_state;

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			sync_q <= 2'b00;
			deb_state <= 1'b0;
			deb_cnt <= '0;
			pluck <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[0], trig}; // metastability guard
			pluck <= 1'b0; // default low, pulse only
			if (!differ)
			begin
				deb_cnt <= '0; // chatter resets the count
			end
			else if (deb_cnt == CNT_W'(DEB_LEN - 1))
			begin
				deb_cnt <= '0;
				deb_state <= sync_q[1]; // confirmed flip
				pluck <= sync_q[1]; // rising flips only
			end
			else
			begin
				deb_cnt <= deb_cnt + 1'b1;
			end
		end
	end

endmodule
